//--- verilog/ip_pkg.sv
`default_nettype none

package ip_pkg;

  // widths of the IPv4 header fields this layer hands to the layer below
  localparam int IPV4_ADDR_BYTES = 4;
  localparam int IPV4_PROTO_W    = 8;
  localparam int IPV4_LEN_W      = 16;

  // address bytes are indexed from the least significant one
  typedef logic [IPV4_ADDR_BYTES-1:0][7:0] ipv4_addr_t;

  typedef logic [IPV4_PROTO_W-1:0] proto_t;

  localparam proto_t PROTO_UDP = 8'd17;

endpackage

`default_nettype wire

//--- verilog/udp_pkg.sv
`default_nettype none

package udp_pkg;

  localparam int UDP_HDR_LEN = 8;

  // the transmit payload buffer depth must be a power of two
  localparam int FIFO_DEPTH = 2048;

  typedef logic [15:0] port_t;

  typedef logic [0:0] cfg_addr_t;

  localparam cfg_addr_t CFG_ADDR_PORT = 1'b0;
  localparam cfg_addr_t CFG_ADDR_IP   = 1'b1;

  // field order matches the wire order with src_port going out first
  typedef struct packed {
    port_t       src_port;
    port_t       dst_port;
    logic [15:0] length;
    logic [15:0] chsum;
  } udp_fields_t;

  // byte b[UDP_HDR_LEN-1] is the first byte on the wire
  typedef union packed {
    udp_fields_t                  f;
    logic [UDP_HDR_LEN-1:0][7:0]  b;
  } udp_hdr_u;

endpackage

`default_nettype wire

//--- verilog/udp_cfg_regs.sv
`default_nettype none
`timescale 1ns/1ps

module udp_cfg_regs (
  input  logic               clk,
  input  logic               fsm_rst,
  input  logic               cfg_req,
  input  udp_pkg::cfg_addr_t cfg_addr,
  input  logic [31:0]        cfg_wdata,
  output logic               cfg_ack,
  output udp_pkg::port_t     local_port,
  output ip_pkg::ipv4_addr_t local_ip
);
  import udp_pkg::*;

  typedef enum logic {
    HS_IDLE,
    HS_ACK
  } hs_state_t;

  hs_state_t state;

  // the register is written on the same edge that raises ack
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state      <= HS_IDLE;
      local_port <= '0;
      local_ip   <= '0;
    end else begin
      case (state)
        HS_IDLE: begin
          if (cfg_req) begin
            state <= HS_ACK;
            case (cfg_addr)
              CFG_ADDR_PORT: local_port <= cfg_wdata[$bits(port_t)-1:0];
              CFG_ADDR_IP:   local_ip   <= cfg_wdata;
              default: ;
            endcase
          end
        end
        HS_ACK: begin
          // hold ack until the master has let go of req
          if (!cfg_req) begin
            state <= HS_IDLE;
          end
        end
        default: state <= HS_IDLE;
      endcase
    end
  end

  assign cfg_ack = (state == HS_ACK);

endmodule

`default_nettype wire

//--- verilog/udp_rx.sv
`default_nettype none
`timescale 1ns/1ps

module udp_rx (
  input  logic               clk,
  input  logic               fsm_rst,
  input  logic [7:0]         rx_d,
  input  logic               rx_v,
  input  logic               rx_sof,
  input  logic               rx_eof,
  input  ip_pkg::proto_t     rx_proto,
  input  ip_pkg::ipv4_addr_t rx_src_ip,
  input  udp_pkg::port_t     local_port,
  output logic [7:0]         app_rx_d,
  output logic               app_rx_v,
  output logic               app_rx_sof,
  output logic               app_rx_eof,
  output logic               app_rx_err,
  output udp_pkg::port_t     app_rx_src_port,
  output ip_pkg::ipv4_addr_t app_rx_src_ip
);
  import ip_pkg::*;
  import udp_pkg::*;

  udp_hdr_u              hdr;
  udp_hdr_u              hdr_nxt;
  logic [IPV4_LEN_W-1:0] cnt;
  logic [IPV4_LEN_W-1:0] cnt_cur;
  logic                  is_udp_q;
  logic                  is_udp;
  logic                  hdr_byte;
  logic                  pay_byte;
  logic                  hdr_full;
  logic                  port_hit;

  // sof restarts the count and takes the protocol straight from the input
  assign is_udp  = rx_sof ? (rx_proto == PROTO_UDP) : is_udp_q;
  assign cnt_cur = rx_sof ? '0 : cnt;

  assign hdr_byte = rx_v && is_udp && (cnt_cur < IPV4_LEN_W'(UDP_HDR_LEN));
  assign pay_byte = rx_v && is_udp && !hdr_byte;
  assign hdr_full = cnt_cur >= IPV4_LEN_W'(UDP_HDR_LEN - 1);

  // header as it stands including the current byte, so an empty payload
  // still sees the complete header on its eof byte
  always_comb begin
    hdr_nxt = hdr;
    if (hdr_byte) begin
      hdr_nxt.b = {hdr.b[UDP_HDR_LEN-2:0], rx_d};
    end
  end

  assign port_hit = (hdr_nxt.f.dst_port == local_port);

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      cnt        <= '0;
      is_udp_q   <= 1'b0;
      app_rx_v   <= 1'b0;
      app_rx_sof <= 1'b0;
      app_rx_eof <= 1'b0;
      app_rx_err <= 1'b0;
    end else begin
      if (rx_v) begin
        cnt <= cnt_cur + 1'b1;
        if (rx_eof) begin
          is_udp_q <= 1'b0;
        end else if (rx_sof) begin
          is_udp_q <= (rx_proto == PROTO_UDP);
        end
      end
      app_rx_v   <= pay_byte && port_hit;
      app_rx_sof <= pay_byte && port_hit && (cnt_cur == IPV4_LEN_W'(UDP_HDR_LEN));
      app_rx_eof <= pay_byte && port_hit && rx_eof;
      // the total byte count is checked against the length field for our port only
      app_rx_err <= rx_v && rx_eof && is_udp && hdr_full && port_hit &&
                    (cnt_cur + 1'b1 != hdr_nxt.f.length);
    end
  end

  always_ff @(posedge clk) begin
    hdr      <= hdr_nxt;
    app_rx_d <= rx_d;
    if (rx_v && rx_sof) begin
      app_rx_src_ip <= rx_src_ip;
    end
  end

  assign app_rx_src_port = hdr.f.src_port;

endmodule

`default_nettype wire

//--- verilog/byte_fifo.sv
`default_nettype none
`timescale 1ns/1ps

module byte_fifo #(
  parameter int DEPTH = 16
) (
  input  logic                   clk,
  input  logic                   fsm_rst,
  input  logic                   wr_en,
  input  logic [7:0]             wr_data,
  input  logic                   rd_en,
  output logic [7:0]             rd_data,
  output logic                   empty,
  output logic [$clog2(DEPTH):0] count
);

  logic [7:0]               mem [DEPTH];
  logic [$clog2(DEPTH)-1:0] wr_ptr;
  logic [$clog2(DEPTH)-1:0] rd_ptr;
  logic                     wr_ok;
  logic                     rd_ok;

  // writes to a full buffer and reads from an empty one are dropped
  assign wr_ok = wr_en && (count != ($clog2(DEPTH)+1)'(DEPTH));
  assign rd_ok = rd_en && !empty;

  always_ff @(posedge clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= wr_data;
    end
    if (rd_ok) begin
      rd_data <= mem[rd_ptr];
    end
  end

  // pointers wrap on their own since DEPTH is a power of two
  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  assign empty = (count == '0);

endmodule

`default_nettype wire

//--- verilog/udp_tx.sv
`default_nettype none
`timescale 1ns/1ps

module udp_tx (
  input  logic                          clk,
  input  logic                          fsm_rst,
  input  udp_pkg::port_t                local_port,
  input  ip_pkg::ipv4_addr_t            local_ip,
  input  logic [7:0]                    app_tx_d,
  input  logic                          app_tx_v,
  input  logic                          app_tx_eof,
  input  udp_pkg::port_t                app_tx_dst_port,
  input  ip_pkg::ipv4_addr_t            app_tx_dst_ip,
  output logic                          app_tx_busy,
  output logic [7:0]                    tx_d,
  output logic                          tx_v,
  output logic                          tx_sof,
  output logic                          tx_eof,
  output ip_pkg::proto_t                tx_proto,
  output ip_pkg::ipv4_addr_t            tx_src_ip,
  output ip_pkg::ipv4_addr_t            tx_dst_ip,
  output logic [ip_pkg::IPV4_LEN_W-1:0] tx_length
);
  import ip_pkg::*;
  import udp_pkg::*;

  typedef enum logic [1:0] {
    S_IDLE,
    S_BUILD,
    S_HDR,
    S_PAY
  } tx_state_t;

  tx_state_t                      state;
  udp_hdr_u                       hdr;
  port_t                          dst_port_q;
  logic [IPV4_LEN_W-1:0]          pay_len;
  logic [IPV4_LEN_W-1:0]          remain;
  logic [$clog2(UDP_HDR_LEN)-1:0] hdr_cnt;
  logic                           hdr_last;
  logic                           start;
  logic                           fifo_wr;
  logic                           fifo_rd;
  logic                           fifo_clr;
  logic                           fifo_empty;
  logic [7:0]                     fifo_rd_data;
  logic [$clog2(FIFO_DEPTH):0]    fifo_count;

  assign start    = (state == S_IDLE) && app_tx_v && app_tx_eof;
  assign hdr_last = (hdr_cnt == ($clog2(UDP_HDR_LEN))'(UDP_HDR_LEN - 1));

  assign fifo_wr  = (state == S_IDLE) && app_tx_v;
  // the first payload byte is fetched during the last header byte
  assign fifo_rd  = !fifo_empty &&
                    (((state == S_HDR) && hdr_last) ||
                     ((state == S_PAY) && (remain != 16'd1)));
  assign fifo_clr = fsm_rst || tx_eof;

  byte_fifo #(
    .DEPTH (FIFO_DEPTH)
  ) byte_fifo_i (
    .clk     (clk),
    .fsm_rst (fifo_clr),
    .wr_en   (fifo_wr),
    .wr_data (app_tx_d),
    .rd_en   (fifo_rd),
    .rd_data (fifo_rd_data),
    .empty   (fifo_empty),
    .count   (fifo_count)
  );

  always_ff @(posedge clk) begin
    if (fsm_rst) begin
      state   <= S_IDLE;
      hdr_cnt <= '0;
      remain  <= '0;
    end else begin
      case (state)
        S_IDLE: begin
          if (start) begin
            state <= S_BUILD;
          end
        end
        S_BUILD: begin
          state   <= S_HDR;
          hdr_cnt <= '0;
          remain  <= pay_len;
        end
        S_HDR: begin
          hdr_cnt <= hdr_cnt + 1'b1;
          if (hdr_last) begin
            state <= S_PAY;
          end
        end
        S_PAY: begin
          remain <= remain - 1'b1;
          if (tx_eof) begin
            state <= S_IDLE;
          end
        end
        default: state <= S_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (start) begin
      dst_port_q <= app_tx_dst_port;
      tx_dst_ip  <= app_tx_dst_ip;
      // the eof byte itself lands in the FIFO on this edge
      pay_len    <= IPV4_LEN_W'(fifo_count) + 1'b1;
    end
    if (state == S_BUILD) begin
      hdr.f     <= '{src_port: local_port,
                     dst_port: dst_port_q,
                     length:   pay_len + IPV4_LEN_W'(UDP_HDR_LEN),
                     chsum:    16'h0000};
      tx_length <= pay_len + IPV4_LEN_W'(UDP_HDR_LEN);
      tx_src_ip <= local_ip;
    end else if (state == S_HDR) begin
      hdr.b <= {hdr.b[UDP_HDR_LEN-2:0], 8'h00};
    end
  end

  assign tx_d        = (state == S_PAY) ? fifo_rd_data : hdr.b[UDP_HDR_LEN-1];
  assign tx_v        = (state == S_HDR) || (state == S_PAY);
  assign tx_sof      = (state == S_HDR) && (hdr_cnt == '0);
  assign tx_eof      = (state == S_PAY) && (remain == 16'd1);
  assign tx_proto    = PROTO_UDP;
  assign app_tx_busy = (state != S_IDLE);

endmodule

`default_nettype wire

//--- verilog/udp_top.sv
`default_nettype none
`timescale 1ns/1ps

module udp_top (
  input  logic                          clk,
  input  logic                          fsm_rst,
  // from the IPv4 layer
  input  logic [7:0]                    rx_d,
  input  logic                          rx_v,
  input  logic                          rx_sof,
  input  logic                          rx_eof,
  input  ip_pkg::proto_t                rx_proto,
  input  ip_pkg::ipv4_addr_t            rx_src_ip,
  // to the application
  output logic [7:0]                    app_rx_d,
  output logic                          app_rx_v,
  output logic                          app_rx_sof,
  output logic                          app_rx_eof,
  output logic                          app_rx_err,
  output udp_pkg::port_t                app_rx_src_port,
  output ip_pkg::ipv4_addr_t            app_rx_src_ip,
  // from the application
  input  logic [7:0]                    app_tx_d,
  input  logic                          app_tx_v,
  input  logic                          app_tx_eof,
  input  udp_pkg::port_t                app_tx_dst_port,
  input  ip_pkg::ipv4_addr_t            app_tx_dst_ip,
  output logic                          app_tx_busy,
  // to the IPv4 layer
  output logic [7:0]                    tx_d,
  output logic                          tx_v,
  output logic                          tx_sof,
  output logic                          tx_eof,
  output ip_pkg::proto_t                tx_proto,
  output ip_pkg::ipv4_addr_t            tx_src_ip,
  output ip_pkg::ipv4_addr_t            tx_dst_ip,
  output logic [ip_pkg::IPV4_LEN_W-1:0] tx_length,
  // configuration
  input  logic                          cfg_req,
  input  udp_pkg::cfg_addr_t            cfg_addr,
  input  logic [31:0]                   cfg_wdata,
  output logic                          cfg_ack
);
  import ip_pkg::*;
  import udp_pkg::*;

  port_t      local_port;
  ipv4_addr_t local_ip;

  udp_cfg_regs udp_cfg_regs_i (
    .clk        (clk),
    .fsm_rst    (fsm_rst),
    .cfg_req    (cfg_req),
    .cfg_addr   (cfg_addr),
    .cfg_wdata  (cfg_wdata),
    .cfg_ack    (cfg_ack),
    .local_port (local_port),
    .local_ip   (local_ip)
  );

  udp_rx udp_rx_i (
    .clk             (clk),
    .fsm_rst         (fsm_rst),
    .rx_d            (rx_d),
    .rx_v            (rx_v),
    .rx_sof          (rx_sof),
    .rx_eof          (rx_eof),
    .rx_proto        (rx_proto),
    .rx_src_ip       (rx_src_ip),
    .local_port      (local_port),
    .app_rx_d        (app_rx_d),
    .app_rx_v        (app_rx_v),
    .app_rx_sof      (app_rx_sof),
    .app_rx_eof      (app_rx_eof),
    .app_rx_err      (app_rx_err),
    .app_rx_src_port (app_rx_src_port),
    .app_rx_src_ip   (app_rx_src_ip)
  );

  udp_tx udp_tx_i (
    .clk             (clk),
    .fsm_rst         (fsm_rst),
    .local_port      (local_port),
    .local_ip        (local_ip),
    .app_tx_d        (app_tx_d),
    .app_tx_v        (app_tx_v),
    .app_tx_eof      (app_tx_eof),
    .app_tx_dst_port (app_tx_dst_port),
    .app_tx_dst_ip   (app_tx_dst_ip),
    .app_tx_busy     (app_tx_busy),
    .tx_d            (tx_d),
    .tx_v            (tx_v),
    .tx_sof          (tx_sof),
    .tx_eof          (tx_eof),
    .tx_proto        (tx_proto),
    .tx_src_ip       (tx_src_ip),
    .tx_dst_ip       (tx_dst_ip),
    .tx_length       (tx_length)
  );

endmodule

`default_nettype wire

//--- sim/tb_udp_checks.svh
`ifndef TB_UDP_CHECKS_SVH
`define TB_UDP_CHECKS_SVH

  task automatic report_mismatch(input string what);
    $display("[FAIL] %0t: %s", $time, what);
    $display("Test FAILED");
    $fatal(1, "mismatch against the model");
  endtask

  task automatic compare_byte(input logic [7:0] got, input logic [7:0] exp,
                              input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s is %02h, expected %02h", what, got, exp));
    end
  endtask

  task automatic compare_port(input port_t got, input port_t exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s is %04h, expected %04h", what, got, exp));
    end
  endtask

  task automatic compare_addr(input ipv4_addr_t got, input ipv4_addr_t exp,
                              input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s is %08h, expected %08h", what, got, exp));
    end
  endtask

  task automatic compare_len(input logic [IPV4_LEN_W-1:0] got,
                             input logic [IPV4_LEN_W-1:0] exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
    end
  endtask

  task automatic compare_proto(input proto_t got, input proto_t exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
    end
  endtask

  task automatic compare_flag(input logic got, input logic exp, input string what);
    if (got !== exp) begin
      report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
    end
  endtask

  // ack must follow each edge of req by one cycle
  task automatic cfg_write(input cfg_addr_t addr, input logic [31:0] data);
    @(negedge clk);
    compare_flag(cfg_ack, 1'b0, "cfg_ack before req");
    cfg_addr  = addr;
    cfg_wdata = data;
    cfg_req   = 1'b1;
    @(negedge clk);
    compare_flag(cfg_ack, 1'b1, "cfg_ack after req");
    cfg_req = 1'b0;
    @(negedge clk);
    compare_flag(cfg_ack, 1'b0, "cfg_ack after req dropped");
    if (addr == CFG_ADDR_PORT) begin
      model_port = data[15:0];
    end else begin
      model_ip = data;
    end
  endtask

  task automatic check_rx_outputs();
    compare_flag(app_rx_v, exp_rx_v, "app_rx_v");
    compare_flag(app_rx_sof, exp_rx_sof, "app_rx_sof");
    compare_flag(app_rx_eof, exp_rx_eof, "app_rx_eof");
    compare_flag(app_rx_err, exp_rx_err, "app_rx_err");
    if (exp_rx_v) begin
      compare_byte(app_rx_d, exp_rx_d, "app_rx_d");
      compare_port(app_rx_src_port, exp_rx_src_port, "app_rx_src_port");
      compare_addr(app_rx_src_ip, exp_rx_src_ip, "app_rx_src_ip");
    end
  endtask

  // checks what the last receive cycle produced and drives the next one
  task automatic rx_step(input logic v, input logic sof, input logic eof,
                         input logic [7:0] d);
    @(negedge clk);
    check_rx_outputs();
    rx_v       = v;
    rx_sof     = sof;
    rx_eof     = eof;
    rx_d       = d;
    exp_rx_v   = 1'b0;
    exp_rx_sof = 1'b0;
    exp_rx_eof = 1'b0;
    exp_rx_err = 1'b0;
  endtask

`endif

//--- sim/tb_udp.sv
`default_nettype none
`timescale 1ns/1ps

module tb_udp;
  import ip_pkg::*;
  import udp_pkg::*;

  localparam int          CLK_PERIOD  = 20;
  localparam int          RST_CYCLES  = 16;
  localparam logic [31:0] SEED        = 32'hfab655cc;
  localparam int          N_CFG       = 6;
  localparam int          N_RX        = 40;
  localparam int          N_TX        = 30;
  localparam int          N_BOTH      = 20;
  localparam int          MAX_PAY     = 64;
  // receive gaps can stretch a packet to about twice its length
  localparam int          MAX_PKT_CYC = 2 * (UDP_HDR_LEN + MAX_PAY) + 8;
  localparam int          LIMIT_CYC   = RST_CYCLES + 8 * (N_CFG + 4) +
                                        (N_RX + N_TX + 2 * N_BOTH) * MAX_PKT_CYC + 200;

  logic                  clk;
  logic                  fsm_rst;
  logic [7:0]            rx_d, app_rx_d, app_tx_d, tx_d;
  logic                  rx_v, rx_sof, rx_eof;
  proto_t                rx_proto, tx_proto;
  ipv4_addr_t            rx_src_ip, app_rx_src_ip, app_tx_dst_ip, tx_src_ip, tx_dst_ip;
  logic                  app_rx_v, app_rx_sof, app_rx_eof, app_rx_err;
  port_t                 app_rx_src_port, app_tx_dst_port;
  logic                  app_tx_v, app_tx_eof, app_tx_busy;
  logic                  tx_v, tx_sof, tx_eof;
  logic [IPV4_LEN_W-1:0] tx_length;
  logic                  cfg_req, cfg_ack;
  cfg_addr_t             cfg_addr;
  logic [31:0]           cfg_wdata;

  // model state and the receive outputs expected at the next falling edge
  port_t                 model_port;
  ipv4_addr_t            model_ip;
  logic                  exp_rx_v, exp_rx_sof, exp_rx_eof, exp_rx_err;
  logic [7:0]            exp_rx_d;
  port_t                 exp_rx_src_port;
  ipv4_addr_t            exp_rx_src_ip;

  udp_top udp_top_i (.*);

  `include "tb_udp_checks.svh"

  task automatic send_rx_packet(input proto_t proto, input ipv4_addr_t src_ip,
                                input udp_fields_t fields, input int pay_len);
    logic [7:0]  bytes[$];
    logic [63:0] hdr_bits;
    logic        fwd;
    logic        last;
    int          n_bytes;
    hdr_bits = fields;
    for (int k = 7; k >= 0; k--) begin
      bytes.push_back(hdr_bits[k*8 +: 8]);
    end
    for (int k = 0; k < pay_len; k++) begin
      bytes.push_back(8'($urandom));
    end
    n_bytes         = bytes.size();
    fwd             = (proto == PROTO_UDP) && (fields.dst_port == model_port);
    exp_rx_src_port = fields.src_port;
    exp_rx_src_ip   = src_ip;
    for (int idx = 0; idx < n_bytes; idx++) begin
      while ($urandom_range(3, 0) == 0) begin
        rx_step(1'b0, 1'b0, 1'b0, 8'($urandom));
      end
      last = (idx == n_bytes - 1);
      rx_step(1'b1, idx == 0, last, bytes[idx]);
      // protocol and source address only count at sof
      if (idx == 0) begin
        rx_proto  = proto;
        rx_src_ip = src_ip;
      end else begin
        rx_proto  = proto_t'($urandom);
        rx_src_ip = ipv4_addr_t'($urandom);
      end
      exp_rx_d   = bytes[idx];
      exp_rx_v   = fwd && (idx >= UDP_HDR_LEN);
      exp_rx_sof = fwd && (idx == UDP_HDR_LEN);
      exp_rx_eof = exp_rx_v && last;
      exp_rx_err = fwd && last && (fields.length != 16'(idx + 1));
    end
    rx_step(1'b0, 1'b0, 1'b0, 8'h00);
    rx_step(1'b0, 1'b0, 1'b0, 8'h00);
  endtask

  // kind 1 misses the port, 2 is not UDP, 3 carries a wrong length
  task automatic rx_random_packet(input int kind);
    udp_fields_t f;
    proto_t      proto;
    int          pay_len;
    pay_len    = $urandom_range(MAX_PAY, 0);
    f.src_port = port_t'($urandom);
    f.dst_port = model_port;
    f.length   = 16'(UDP_HDR_LEN + pay_len);
    f.chsum    = 16'($urandom);
    proto      = PROTO_UDP;
    case (kind)
      1: f.dst_port = model_port ^ port_t'($urandom_range(16'hffff, 1));
      2: proto = proto_t'($urandom_range(255, 18));
      3: f.length = f.length ^ 16'($urandom_range(16'hffff, 1));
      default: ;
    endcase
    send_rx_packet(proto, ipv4_addr_t'($urandom), f, pay_len);
  endtask

  task automatic send_tx_packet(input int pay_len, input port_t dst_port,
                                input ipv4_addr_t dst_ip);
    logic [7:0]  exp_bytes[$];
    logic [7:0]  pay[$];
    logic [63:0] hdr_bits;
    logic [15:0] udp_len;
    int          n_bytes;
    udp_len  = 16'(pay_len + UDP_HDR_LEN);
    hdr_bits = {model_port, dst_port, udp_len, 16'h0000};
    for (int k = 7; k >= 0; k--) begin
      exp_bytes.push_back(hdr_bits[k*8 +: 8]);
    end
    for (int k = 0; k < pay_len; k++) begin
      pay.push_back(8'($urandom));
      exp_bytes.push_back(pay[k]);
    end
    n_bytes = exp_bytes.size();
    @(negedge clk);
    while (app_tx_busy) begin
      @(negedge clk);
    end
    for (int k = 0; k < pay_len; k++) begin
      if (k > 0) begin
        @(negedge clk);
        compare_flag(app_tx_busy, 1'b0, "app_tx_busy while writing");
      end
      compare_flag(tx_v, 1'b0, "tx_v while writing");
      app_tx_v   = 1'b1;
      app_tx_d   = pay[k];
      app_tx_eof = (k == pay_len - 1);
      // destination is only meant to be taken with eof
      app_tx_dst_port = app_tx_eof ? dst_port : port_t'($urandom);
      app_tx_dst_ip   = app_tx_eof ? dst_ip : ipv4_addr_t'($urandom);
    end
    @(negedge clk);
    app_tx_v        = 1'b0;
    app_tx_eof      = 1'b0;
    app_tx_dst_port = port_t'($urandom);
    app_tx_dst_ip   = ipv4_addr_t'($urandom);
    compare_flag(app_tx_busy, 1'b1, "app_tx_busy the cycle after eof");
    compare_flag(tx_v, 1'b0, "tx_v the cycle after eof");
    for (int k = 0; k < n_bytes; k++) begin
      @(negedge clk);
      compare_flag(tx_v, 1'b1, "tx_v");
      compare_flag(tx_sof, k == 0, "tx_sof");
      compare_flag(tx_eof, k == n_bytes - 1, "tx_eof");
      compare_flag(app_tx_busy, 1'b1, "app_tx_busy during the packet");
      compare_byte(tx_d, exp_bytes[k], "tx_d");
      compare_len(tx_length, udp_len, "tx_length");
      compare_proto(tx_proto, PROTO_UDP, "tx_proto");
      compare_addr(tx_src_ip, model_ip, "tx_src_ip");
      compare_addr(tx_dst_ip, dst_ip, "tx_dst_ip");
    end
    @(negedge clk);
    compare_flag(app_tx_busy, 1'b0, "app_tx_busy after tx_eof");
    compare_flag(tx_v, 1'b0, "tx_v after tx_eof");
  endtask

  task automatic tx_random_packet();
    send_tx_packet($urandom_range(MAX_PAY, 1), port_t'($urandom), ipv4_addr_t'($urandom));
  endtask

  initial begin
    clk = 1'b0;
    forever begin
      #(CLK_PERIOD / 2);
      clk = ~clk;
    end
  end

  initial begin
    #(LIMIT_CYC * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d clock cycles", LIMIT_CYC);
    $display("Test FAILED");
    $fatal(1, "watchdog expired");
  end

  initial begin
    void'($urandom(SEED));
    fsm_rst         = 1'b1;
    rx_d            = 8'h00;
    rx_v            = 1'b0;
    rx_sof          = 1'b0;
    rx_eof          = 1'b0;
    rx_proto        = '0;
    rx_src_ip       = '0;
    app_tx_d        = 8'h00;
    app_tx_v        = 1'b0;
    app_tx_eof      = 1'b0;
    app_tx_dst_port = '0;
    app_tx_dst_ip   = '0;
    cfg_req         = 1'b0;
    cfg_addr        = CFG_ADDR_PORT;
    cfg_wdata       = '0;
    model_port      = '0;
    model_ip        = '0;
    exp_rx_v        = 1'b0;
    exp_rx_sof      = 1'b0;
    exp_rx_eof      = 1'b0;
    exp_rx_err      = 1'b0;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk);
    fsm_rst = 1'b0;
    compare_flag(|{cfg_ack, app_rx_v, app_rx_sof, app_rx_eof, app_rx_err,
                   tx_v, tx_sof, tx_eof, app_tx_busy}, 1'b0, "control outputs after reset");
    for (int i = 0; i < N_CFG; i++) begin
      cfg_write(CFG_ADDR_PORT, $urandom);
      cfg_write(CFG_ADDR_IP, $urandom);
    end
    for (int i = 0; i < N_TX; i++) begin
      if (i % 10 == 5) begin
        cfg_write(CFG_ADDR_IP, $urandom);
        cfg_write(CFG_ADDR_PORT, $urandom);
      end
      tx_random_packet();
    end
    for (int i = 0; i < N_RX; i++) begin
      rx_random_packet(i % 4);
    end
    // both paths at once
    fork
      for (int i = 0; i < N_BOTH; i++) begin
        rx_random_packet(i % 4);
      end
      for (int j = 0; j < N_BOTH; j++) begin
        tx_random_packet();
      end
    join
    $display("Test OK");
    $finish;
  end

endmodule

`default_nettype wire

//--- flist.f
+incdir+sim
verilog/ip_pkg.sv
verilog/udp_pkg.sv
verilog/udp_cfg_regs.sv
verilog/udp_rx.sv
verilog/byte_fifo.sv
verilog/udp_tx.sv
verilog/udp_top.sv
sim/tb_udp.sv

//--- run_sim.sh
#!/bin/sh
cd "$(dirname "$0")" &&
  verilator --binary --timing -j 0 -f flist.f --top-module tb_udp -o tb_udp &&
  ./obj_dir/tb_udp || exit 1
